//--- mem_ctrl_pkg.sv
/* banked memory controller
   shared sizes and types */
package mem_ctrl_pkg;

    localparam int num_ports = 4;
    localparam int num_banks = 4;
    localparam int addr_w = 12;
    localparam int data_w = 32;
    localparam int bank_w = 2;                   // top address bits pick the bank
    localparam int offset_w = 10;
    localparam int bank_depth = 1 << offset_w;   // 1024 words

    typedef logic [$clog2(num_ports)-1:0] port_idx_t;
    typedef logic [bank_w-1:0]            bank_idx_t;
    typedef logic [offset_w-1:0]          offset_t;
    typedef logic [data_w-1:0]            data_t;
    typedef logic [addr_w-1:0]            addr_t;

    // one port, one cycle, 58 bits
    typedef struct packed {
        logic  rd_en;
        addr_t rd_addr;
        logic  wr_en;
        addr_t wr_addr;
        data_t wr_data;
    } port_req_t;

    // completion seen by a port one cycle later, 34 bits
    typedef struct packed {
        logic  rd_valid;
        data_t rd_data;
        logic  wr_done;
    } port_resp_t;

    typedef struct packed {
        logic    en;
        offset_t offset;
    } bank_rd_t;

    typedef struct packed {
        logic    en;
        offset_t offset;
        data_t   data;
    } bank_wr_t;

    function automatic bank_idx_t bank_of(addr_t addr);
        return addr[addr_w-1 -: bank_w];
    endfunction

    function automatic offset_t offset_of(addr_t addr);
        return addr[offset_w-1:0];
    endfunction

endpackage

//--- bank_arbiter.sv
/* per-bank fixed-priority arbiter */
`timescale 1ns/1ps

module bank_arbiter (
    input  mem_ctrl_pkg::bank_idx_t                                bank_id,
    input  mem_ctrl_pkg::port_req_t [mem_ctrl_pkg::num_ports-1:0] req,
    output mem_ctrl_pkg::bank_rd_t                                 rd_cmd,
    output mem_ctrl_pkg::bank_wr_t                                 wr_cmd,
    output logic [mem_ctrl_pkg::num_ports-1:0]                     rd_grant,
    output logic [mem_ctrl_pkg::num_ports-1:0]                     wr_grant
);
    import mem_ctrl_pkg::*;

    logic [num_ports-1:0] rd_hit;   // port wants to read this bank
    logic [num_ports-1:0] wr_hit;   // port wants to write this bank
    port_idx_t            rd_sel;
    port_idx_t            wr_sel;

    // bank decode per port
    always_comb begin
        for (int p = 0; p < num_ports; p++) begin
            rd_hit[p] = req[p].rd_en && (bank_of(req[p].rd_addr) == bank_id);
            wr_hit[p] = req[p].wr_en && (bank_of(req[p].wr_addr) == bank_id);
        end
    end

    // scan downwards so the lowest requesting port is left in sel
    always_comb begin
        rd_sel = '0;
        wr_sel = '0;
        for (int p = num_ports - 1; p >= 0; p--) begin
            if (rd_hit[p]) begin
                rd_sel = port_idx_t'(p);
            end
            if (wr_hit[p]) begin
                wr_sel = port_idx_t'(p);
            end
        end
    end

    always_comb begin
        rd_grant = '0;
        wr_grant = '0;
        rd_grant[rd_sel] = |rd_hit;   // stays zero when nobody asks
        wr_grant[wr_sel] = |wr_hit;
    end

    // forward the winner's offset and data to the bank
    always_comb begin
        rd_cmd.en     = |rd_hit;
        rd_cmd.offset = offset_of(req[rd_sel].rd_addr);
        wr_cmd.en     = |wr_hit;
        wr_cmd.offset = offset_of(req[wr_sel].wr_addr);
        wr_cmd.data   = req[wr_sel].wr_data;
    end

    // a port is granted exactly when it asks and no lower port asks
    always_comb begin
        logic [num_ports-1:0] lower;
        for (int p = 0; p < num_ports; p++) begin
            lower = num_ports'((1 << p) - 1);   // ports below p
            assert (rd_grant[p] == (rd_hit[p] && ((rd_hit & lower) == '0)))
                else $error("bank %0d: read grant wrong for port %0d", bank_id, p);
            assert (wr_grant[p] == (wr_hit[p] && ((wr_hit & lower) == '0)))
                else $error("bank %0d: write grant wrong for port %0d", bank_id, p);
        end
    end

endmodule

//--- sram_bank.sv
/* single-port-pair sram bank */
`timescale 1ns/1ps

module sram_bank (
    input  logic                   clk,
    input  mem_ctrl_pkg::bank_rd_t rd_cmd,
    input  mem_ctrl_pkg::bank_wr_t wr_cmd,
    output mem_ctrl_pkg::data_t    rd_data
);
    import mem_ctrl_pkg::*;

    data_t mem [bank_depth];   // 1024 x 32 storage

    // one write port, updated at the edge
    always_ff @(posedge clk) begin
        if (wr_cmd.en) begin
            mem[wr_cmd.offset] <= wr_cmd.data;
        end
    end

    // registered read
    // same-edge write lands after the sample so the old word comes out
    always_ff @(posedge clk) begin
        if (rd_cmd.en) begin
            rd_data <= mem[rd_cmd.offset];
        end
    end

endmodule

//--- read_return.sv
/* read data and status return */
`timescale 1ns/1ps

module read_return (
    input  logic                                                            clk,
    input  logic                                                            reset,
    input  logic [mem_ctrl_pkg::num_banks-1:0][mem_ctrl_pkg::num_ports-1:0] rd_grant,
    input  logic [mem_ctrl_pkg::num_banks-1:0][mem_ctrl_pkg::num_ports-1:0] wr_grant,
    input  mem_ctrl_pkg::data_t [mem_ctrl_pkg::num_banks-1:0]               bank_data,
    output mem_ctrl_pkg::port_resp_t [mem_ctrl_pkg::num_ports-1:0]          resp
);
    import mem_ctrl_pkg::*;

    // grants regrouped per port, one bit per bank
    logic [num_ports-1:0][num_banks-1:0] rd_by_port;
    logic [num_ports-1:0][num_banks-1:0] wr_by_port;
    logic [num_ports-1:0][num_banks-1:0] rd_by_port_q;
    logic [num_ports-1:0][num_banks-1:0] wr_by_port_q;

    always_comb begin
        for (int p = 0; p < num_ports; p++) begin
            for (int b = 0; b < num_banks; b++) begin
                rd_by_port[p][b] = rd_grant[b][p];
                wr_by_port[p][b] = wr_grant[b][p];
            end
        end
    end

    // grants line up with the bank's registered read word
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_by_port_q <= '0;
            wr_by_port_q <= '0;
        end else begin
            rd_by_port_q <= rd_by_port;
            wr_by_port_q <= wr_by_port;
        end
    end

    always_comb begin
        for (int p = 0; p < num_ports; p++) begin
            resp[p].rd_valid = |rd_by_port_q[p];
            resp[p].wr_done  = |wr_by_port_q[p];
            resp[p].rd_data  = '0;   // quiet when nothing was read
            for (int b = 0; b < num_banks; b++) begin
                if (rd_by_port_q[p][b]) begin
                    resp[p].rd_data = bank_data[b];
                end
            end
        end
    end

    // a port carries one address per direction, so across all four
    // arbiters at most one bank may grant it
    for (genvar p = 0; p < num_ports; p++) begin : g_chk
        a_rd_one_bank : assert property (
            @(posedge clk) disable iff (reset) $onehot0(rd_by_port[p])
        ) else $error("port %0d read granted by several banks", p);

        a_wr_one_bank : assert property (
            @(posedge clk) disable iff (reset) $onehot0(wr_by_port[p])
        ) else $error("port %0d write granted by several banks", p);
    end

endmodule

//--- banked_mem_ctrl.sv
/* four-port banked memory controller */
`timescale 1ns/1ps

module banked_mem_ctrl (
    input  logic                                                   clk,
    input  logic                                                   reset,
    input  mem_ctrl_pkg::port_req_t  [mem_ctrl_pkg::num_ports-1:0] req,
    output mem_ctrl_pkg::port_resp_t [mem_ctrl_pkg::num_ports-1:0] resp
);
    import mem_ctrl_pkg::*;

    bank_rd_t [num_banks-1:0]            rd_cmd;     // arbiter to bank
    bank_wr_t [num_banks-1:0]            wr_cmd;
    logic [num_banks-1:0][num_ports-1:0] rd_grant;   // arbiter to return stage
    logic [num_banks-1:0][num_ports-1:0] wr_grant;
    data_t [num_banks-1:0]               bank_data;  // registered read words

    // one arbiter and one sram per bank
    for (genvar b = 0; b < num_banks; b++) begin : g_bank
        bank_arbiter u_arb (
            .bank_id  (bank_idx_t'(b)),
            .req      (req),
            .rd_cmd   (rd_cmd[b]),
            .wr_cmd   (wr_cmd[b]),
            .rd_grant (rd_grant[b]),
            .wr_grant (wr_grant[b])
        );

        sram_bank u_sram (
            .clk     (clk),
            .rd_cmd  (rd_cmd[b]),
            .wr_cmd  (wr_cmd[b]),
            .rd_data (bank_data[b])
        );
    end

    read_return u_ret (
        .clk       (clk),
        .reset     (reset),
        .rd_grant  (rd_grant),
        .wr_grant  (wr_grant),
        .bank_data (bank_data),
        .resp      (resp)
    );

endmodule

//--- tb_clock_gen.sv
/* testbench clock and reset */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 10 ns period
    end

    // reset held for 10 cycles, dropped away from the rising edge
    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

//--- tb_banked_mem_ctrl.sv
/* banked memory controller testbench
   directed table plus random traffic against a reference model */
`timescale 1ns/1ps

module tb_banked_mem_ctrl;
    import mem_ctrl_pkg::*;

    typedef port_req_t  [num_ports-1:0] req_row_t;
    typedef port_resp_t [num_ports-1:0] resp_row_t;

    localparam int reset_timeout = 100;   // cycles
    localparam int random_rows = 200;

    logic      clk;
    logic      reset;
    req_row_t  req;
    resp_row_t resp;

    req_row_t             stim_q[$];    // one entry per cycle
    resp_row_t            exp_q[$];     // expected response for that row
    logic [num_ports-1:0] known_q[$];   // rd_data comparable per port

    data_t       model_mem   [1 << addr_w];
    logic        model_known [1 << addr_w];
    logic [31:0] rand_state = 32'd24941;

    tb_clock_gen u_clk (
        .clk   (clk),
        .reset (reset)
    );

    banked_mem_ctrl dut (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .resp  (resp)
    );

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic port_req_t read_req(addr_t addr);
        port_req_t r;
        r = '0;
        r.rd_en   = 1'b1;
        r.rd_addr = addr;
        return r;
    endfunction

    function automatic port_req_t write_req(addr_t addr, data_t data);
        port_req_t r;
        r = '0;
        r.wr_en   = 1'b1;
        r.wr_addr = addr;
        r.wr_data = data;
        return r;
    endfunction

    // addresses confined to 4 words per bank so ports collide often
    function automatic port_req_t rand_req();
        port_req_t   r;
        logic [31:0] ctl;
        ctl = next_rand();
        r.rd_en   = ctl[31];
        r.wr_en   = ctl[30];
        r.rd_addr = {ctl[29:28], 8'h00, ctl[27:26]};
        r.wr_addr = {ctl[25:24], 8'h00, ctl[23:22]};
        r.wr_data = next_rand();
        return r;
    endfunction

    task automatic add_row(input port_req_t r0, input port_req_t r1,
                           input port_req_t r2, input port_req_t r3);
        req_row_t row;
        row[0] = r0;
        row[1] = r1;
        row[2] = r2;
        row[3] = r3;
        stim_q.push_back(row);
    endtask

    // lowest port wins per bank, all reads see the word before this cycle's writes
    task automatic model_step(input req_row_t row, output resp_row_t exp,
                              output logic [num_ports-1:0] known);
        bank_idx_t            bank;
        logic [num_banks-1:0] rd_busy;
        logic [num_banks-1:0] wr_busy;
        exp     = '0;
        known   = '0;
        rd_busy = '0;
        wr_busy = '0;
        for (int p = 0; p < num_ports; p++) begin
            bank = row[p].rd_addr[addr_w-1 -: bank_w];
            if (row[p].rd_en && !rd_busy[bank]) begin
                rd_busy[bank]   = 1'b1;
                exp[p].rd_valid = 1'b1;
                exp[p].rd_data  = model_mem[row[p].rd_addr];
                known[p]        = model_known[row[p].rd_addr];
            end
        end
        for (int p = 0; p < num_ports; p++) begin
            bank = row[p].wr_addr[addr_w-1 -: bank_w];
            if (row[p].wr_en && !wr_busy[bank]) begin
                wr_busy[bank]                = 1'b1;
                exp[p].wr_done               = 1'b1;
                model_mem[row[p].wr_addr]   = row[p].wr_data;
                model_known[row[p].wr_addr] = 1'b1;
            end
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error: %s is 0x%08h, expected 0x%08h", name, actual, expected);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    task automatic check_row(input resp_row_t exp, input logic [num_ports-1:0] known);
        for (int p = 0; p < num_ports; p++) begin
            check_value($sformatf("resp[%0d].rd_valid", p), 32'(resp[p].rd_valid),
                        32'(exp[p].rd_valid));
            check_value($sformatf("resp[%0d].wr_done", p), 32'(resp[p].wr_done),
                        32'(exp[p].wr_done));
            if (exp[p].rd_valid && known[p]) begin
                check_value($sformatf("resp[%0d].rd_data", p), resp[p].rd_data,
                            exp[p].rd_data);
            end
        end
    endtask

    task automatic build_table();
        req_row_t row;
        for (int a = 0; a < (1 << addr_w); a++) begin
            model_known[a] = 1'b0;
        end
        // one write per bank, then every port reads its word back
        add_row(write_req(12'h000, 32'h1111_0000), write_req(12'h401, 32'h2222_0001),
                write_req(12'h802, 32'h3333_0002), write_req(12'hC03, 32'h4444_0003));
        add_row(read_req(12'h000), read_req(12'h401), read_req(12'h802), read_req(12'hC03));
        // preload four words of bank 1
        for (int k = 0; k < num_ports; k++) begin
            row = '0;
            row[0] = write_req(12'h410 + addr_t'(k), 32'h5500_0000 + data_t'(k));
            stim_q.push_back(row);
        end
        // four-way write conflict on bank 1
        add_row(write_req(12'h410, 32'hC0DE_0000), write_req(12'h411, 32'hBAD0_0001),
                write_req(12'h412, 32'hBAD0_0002), write_req(12'h413, 32'hBAD0_0003));
        for (int k = 0; k < num_ports; k++) begin
            row = '0;
            row[k] = read_req(12'h410 + addr_t'(k));
            stim_q.push_back(row);
        end
        // three readers on bank 0, port 1 wins
        add_row('0, read_req(12'h000), read_req(12'h001), read_req(12'h3FF));
        // read and write of one word in the same cycle, then read again
        add_row(read_req(12'h802), write_req(12'h802, 32'h7777_0802), '0, '0);
        add_row('0, '0, read_req(12'h802), '0);
        // seed the random window so its reads have known data
        for (int k = 0; k < 4; k++) begin
            row = '0;
            for (int b = 0; b < num_banks; b++) begin
                row[b] = write_req({bank_idx_t'(b), 8'h00, 2'(k)}, next_rand());
            end
            stim_q.push_back(row);
        end
        for (int i = 0; i < random_rows; i++) begin
            add_row(rand_req(), rand_req(), rand_req(), rand_req());
        end
    endtask

    initial begin
        resp_row_t            exp_row;
        logic [num_ports-1:0] known_row;
        int                   cycles;

        // every port reads its own bank while reset is held
        for (int p = 0; p < num_ports; p++) begin
            req[p] = read_req({bank_idx_t'(p), 10'h000});
        end
        build_table();
        for (int i = 0; i < stim_q.size(); i++) begin
            model_step(stim_q[i], exp_row, known_row);
            exp_q.push_back(exp_row);
            known_q.push_back(known_row);
        end

        // no read may complete before reset is released
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > reset_timeout) begin
                $display("reset was not released within %0d cycles", reset_timeout);
                $display("** FAIL **");
                $fatal(1);
            end
            if (reset) begin
                check_row('0, '0);
            end
        end while (reset);
        req = '0;

        @(negedge clk);
        check_row('0, '0);   // quiet after reset

        // drive on the falling edge, check one cycle later
        for (int i = 0; i < stim_q.size(); i++) begin
            req = stim_q[i];
            @(negedge clk);
            check_row(exp_q[i], known_q[i]);
        end
        req = '0;

        $display("** PASS **");
        $finish;
    end

endmodule

//--- files.f
mem_ctrl_pkg.sv
bank_arbiter.sv
sram_bank.sv
read_return.sv
banked_mem_ctrl.sv
tb_clock_gen.sv
tb_banked_mem_ctrl.sv

//--- Makefile
TOP := tb_banked_mem_ctrl

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) \
		-f files.f -Mdir obj_dir -o $(TOP)

run: build
	./obj_dir/$(TOP)

lint:
	verilator --lint-only --timing -Wall --top-module banked_mem_ctrl -f files.f

clean:
	rm -rf obj_dir
